/* Makefile */
# Verilator build and run for the wormhole flit mux

VERILATOR ?= verilator
TOP       ?= tb_flit_mux
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, fails unless the pass line appears"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR TIMESCALE VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)

/* design/flit_counter.sv */
// #########################################################
// body flit counter
// counts down the body flits of the locked packet and
// flags the last one
// #########################################################

`default_nettype none

module flit_counter import flit_mux_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_i,
  // head taken, start a new count
  input  wire logic      load_i,
  input  wire flit_len_t len_i,
  // one body flit taken
  input  wire logic      dec_i,
  output logic           last_o
);

  // body flits still to come
  flit_len_t count_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= len_i;
    end else if (dec_i) begin
      // never below zero, controller only decrements in a burst
      if (count_q != '0) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // one body flit left, the next one taken ends the packet
  assign last_o = (count_q == flit_len_t'(1));

endmodule

`default_nettype wire

/* design/flit_mux_datapath.sv */
// #########################################################
// flit mux datapath
// selects the granted flit and registers it onto the
// output port, extracts head flags and length
// #########################################################

`default_nettype none

module flit_mux_datapath import flit_mux_pkg::*; (
  input  wire logic    clk_i,
  input  wire logic    rst_i,
  input  wire flit_t   in_flit_i [num_inputs],
  input  wire in_idx_t sel_idx_i,
  // flit of sel_idx_i is accepted this cycle
  input  wire logic    take_i,
  output logic         out_valid_o,
  output flit_t        out_flit_o,
  output in_mask_t     head_flags_o,
  output flit_len_t    sel_len_o
);

  flit_t sel_flit;

  assign sel_flit  = in_flit_i[sel_idx_i];
  // length is only looked at when the selected flit is a head
  assign sel_len_o = sel_flit.len;

  always_comb begin
    for (int i = 0; i < num_inputs; i++) begin
      head_flags_o[i] = in_flit_i[i].is_head;
    end
  end

  // output valid follows take by one cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= take_i;
    end
  end

  // flit register, only loads on an accepted flit
  always_ff @(posedge clk_i) begin
    if (take_i) begin
      out_flit_o <= sel_flit;
    end
  end

endmodule

`default_nettype wire

/* design/flit_mux_pkg.sv */
// #########################################################
// flit mux package
// widths, flit layout and controller states shared by the
// wormhole packet multiplexer
// #########################################################

`default_nettype none

package flit_mux_pkg;

  // number of mux inputs, a power of two
  localparam int num_inputs = 4;
  // width of an input index
  localparam int idx_w = 2;
  // width of the body-flit count, so 0 to 7 body flits
  localparam int len_w = 3;
  // payload width
  localparam int data_w = 16;

  // input index
  typedef logic [idx_w-1:0] in_idx_t;

  // one bit per input, for valid levels and grants
  typedef logic [num_inputs-1:0] in_mask_t;

  // body-flit count of a packet
  typedef logic [len_w-1:0] flit_len_t;

  // one flit as seen on every input and on the output
  typedef struct packed {
    // set on the first flit of a packet
    logic                is_head;
    // body count, only meaningful in a head
    flit_len_t           len;
    // source tag written by the sender
    in_idx_t             src;
    logic [data_w-1:0]   payload;
  } flit_t;

  // wormhole controller states
  typedef enum logic {
    // waiting for a head, arbiter is free to choose
    IDLE,
    // output locked to one input until its last body flit
    BURST
  } ctrl_state_e;

endpackage

`default_nettype wire

/* design/flit_mux_top.sv */
// #########################################################
// wormhole flit mux, top level
// four inputs onto one output port, round-robin per packet
// #########################################################

`default_nettype none

module flit_mux_top import flit_mux_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_i,
  input  wire in_mask_t in_valid_i,
  input  wire flit_t    in_flit_i [num_inputs],
  input  wire logic     stall_i,
  output in_mask_t      in_grant_o,
  output logic          out_valid_o,
  output flit_t         out_flit_o
);

  // arbiter handshake
  in_mask_t  arb_req;
  in_mask_t  arb_grant;
  in_idx_t   arb_idx;
  logic      arb_hold;
  logic      arb_update;

  // counter and datapath control
  logic      cnt_load;
  logic      cnt_dec;
  logic      cnt_last;
  logic      take;
  in_idx_t   sel_idx;
  in_mask_t  head_flags;
  flit_len_t sel_len;

  wormhole_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .valid_i     (in_valid_i),
    .head_i      (head_flags),
    .stall_i     (stall_i),
    .arb_grant_i (arb_grant),
    .arb_idx_i   (arb_idx),
    .head_len_i  (sel_len),
    .last_i      (cnt_last),
    .arb_req_o   (arb_req),
    .hold_o      (arb_hold),
    .update_o    (arb_update),
    .load_o      (cnt_load),
    .dec_o       (cnt_dec),
    .take_o      (take),
    .sel_idx_o   (sel_idx),
    .in_grant_o  (in_grant_o)
  );

  rr_arbiter u_arb (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (arb_req),
    .hold_i      (arb_hold),
    .update_i    (arb_update),
    .grant_o     (arb_grant),
    .grant_idx_o (arb_idx)
  );

  flit_counter u_cnt (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .load_i (cnt_load),
    .len_i  (sel_len),
    .dec_i  (cnt_dec),
    .last_o (cnt_last)
  );

  flit_mux_datapath u_dp (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .in_flit_i    (in_flit_i),
    .sel_idx_i    (sel_idx),
    .take_i       (take),
    .out_valid_o  (out_valid_o),
    .out_flit_o   (out_flit_o),
    .head_flags_o (head_flags),
    .sel_len_o    (sel_len)
  );

endmodule

`default_nettype wire

/* design/rr_arbiter.sv */
// #########################################################
// round-robin arbiter
// rotating priority pointer, one-hot grant plus index;
// pointer can be pinned on the winner or moved past it
// #########################################################

`default_nettype none

module rr_arbiter import flit_mux_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_i,
  input  wire in_mask_t req_i,
  // keep the current winner at highest priority
  input  wire logic     hold_i,
  // move priority to the input after the winner
  input  wire logic     update_i,
  output in_mask_t      grant_o,
  output in_idx_t       grant_idx_o
);

  // index that currently has highest priority
  in_idx_t ptr_q;
  in_idx_t ptr_d;
  in_idx_t next_idx;

  logic [2*num_inputs-1:0] req_wide;
  logic [2*num_inputs-1:0] sel_wide;
  in_mask_t                rot_req;
  in_mask_t                rot_sel;
  in_idx_t                 low_idx;
  logic [idx_w:0]          idx_sum;

  // rotate right so the pointer's input lands on bit 0
  assign req_wide = {req_i, req_i} >> ptr_q;
  assign rot_req  = req_wide[num_inputs-1:0];

  // lowest set bit wins in rotated space
  assign rot_sel = rot_req & (~rot_req + 1'b1);

  // rotate back by the same amount
  assign sel_wide = {rot_sel, rot_sel} << ptr_q;
  assign grant_o  = sel_wide[2*num_inputs-1 -: num_inputs];

  // position of the winner in rotated space
  always_comb begin
    low_idx = '0;
    for (int i = 0; i < num_inputs; i++) begin
      if (rot_sel[i]) begin
        low_idx = in_idx_t'(i);
      end
    end
  end

  // undo the rotation on the index, modulo num_inputs
  // with no request this falls back to the pointer itself, which
  // during a burst is the pinned winner
  assign idx_sum = {1'b0, ptr_q} + {1'b0, low_idx};
  assign grant_idx_o = (idx_sum >= (idx_w+1)'(num_inputs)) ?
                       in_idx_t'(idx_sum - (idx_w+1)'(num_inputs)) : in_idx_t'(idx_sum);

  // input after the winner, wrapping
  assign next_idx = (grant_idx_o == in_idx_t'(num_inputs - 1)) ? '0 : grant_idx_o + 1'b1;

  // update has priority over hold
  always_comb begin
    ptr_d = ptr_q;
    if (update_i) begin
      ptr_d = next_idx;
    end else if (hold_i) begin
      ptr_d = grant_idx_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else begin
      ptr_q <= ptr_d;
    end
  end

endmodule

`default_nettype wire

/* design/wormhole_ctrl.sv */
// #########################################################
// wormhole controller
// locks the output to one input for a whole packet and
// drives arbiter, counter and the source grants
// #########################################################

`default_nettype none

module wormhole_ctrl import flit_mux_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_i,
  input  wire in_mask_t  valid_i,
  input  wire in_mask_t  head_i,
  input  wire logic      stall_i,
  input  wire in_mask_t  arb_grant_i,
  input  wire in_idx_t   arb_idx_i,
  // length field of the currently selected flit
  input  wire flit_len_t head_len_i,
  input  wire logic      last_i,
  output in_mask_t       arb_req_o,
  output logic           hold_o,
  output logic           update_o,
  output logic           load_o,
  output logic           dec_o,
  output logic           take_o,
  output in_idx_t        sel_idx_o,
  output in_mask_t       in_grant_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // input that owns the output during a burst
  in_idx_t  lock_idx_q;
  in_mask_t lock_mask;

  assign lock_mask = in_mask_t'(1) << lock_idx_q;

  always_comb begin
    state_d    = state_q;
    arb_req_o  = '0;
    hold_o     = 1'b0;
    update_o   = 1'b0;
    load_o     = 1'b0;
    dec_o      = 1'b0;
    take_o     = 1'b0;
    sel_idx_o  = arb_idx_i;
    in_grant_o = '0;
    unique case (state_q)
      IDLE: begin
        // only valid heads compete
        arb_req_o = valid_i & head_i;
        take_o    = (|arb_grant_i) & ~stall_i;
        if (take_o) begin
          in_grant_o = arb_grant_i;
          if (head_len_i == '0) begin
            // single flit packet, release right away
            update_o = 1'b1;
          end else begin
            hold_o  = 1'b1;
            load_o  = 1'b1;
            state_d = BURST;
          end
        end
      end
      BURST: begin
        sel_idx_o = lock_idx_q;
        // missing body flit just waits, like a stall
        take_o    = valid_i[lock_idx_q] & ~stall_i;
        if (take_o) begin
          in_grant_o = lock_mask;
          dec_o      = 1'b1;
          if (last_i) begin
            update_o = 1'b1;
            state_d  = IDLE;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= IDLE;
      lock_idx_q <= '0;
    end else begin
      state_q <= state_d;
      // latch the winner when its burst begins
      if (load_o) begin
        lock_idx_q <= arb_idx_i;
      end
    end
  end

endmodule

`default_nettype wire

/* project.f */
design/flit_mux_pkg.sv
design/rr_arbiter.sv
design/flit_counter.sv
design/wormhole_ctrl.sv
design/flit_mux_datapath.sv
design/flit_mux_top.sv
tb/flit_mux_props.sv
tb/tb_flit_mux.sv

/* tb/flit_mux_props.sv */
// ##########################################################
// flit mux properties
// grant, stall and output valid timing, bound to the top
// ##########################################################

`default_nettype none

module flit_mux_props
  import flit_mux_pkg::*;
(
  input wire logic     clk_i,
  input wire logic     rst_i,
  input wire logic     stall_i,
  input wire in_mask_t grant_i,
  input wire logic     out_valid_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // at most one source sees its flit taken
  a_grant_onehot: assert property (
    @(posedge clk_i) disable iff (rst_i) $onehot0(grant_i)
  ) else $error("more than one grant bit set");

  // stall blocks every grant in the same cycle
  a_no_grant_on_stall: assert property (
    @(posedge clk_i) disable iff (rst_i) stall_i |-> grant_i == '0
  ) else $error("grant issued while stalled");

  // output valid trails the accepted flit by one cycle
  a_valid_follows_grant: assert property (
    @(posedge clk_i) disable iff (rst_i) out_valid_i == $past(|grant_i)
  ) else $error("output valid does not follow the grant");

  a_quiet_after_reset: assert property (
    @(posedge clk_i) $past(rst_i) |-> !out_valid_i
  ) else $error("output valid right after reset");

endmodule

bind flit_mux_top flit_mux_props u_props (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .stall_i     (stall_i),
  .grant_i     (in_grant_o),
  .out_valid_i (out_valid_o)
);

`default_nettype wire

/* tb/tb_flit_mux.sv */
// ##########################################################
// testbench for the wormhole flit mux
// lfsr packet sources, reference arbitration model and a
// cycle by cycle comparison of grant and output port
// ##########################################################

`default_nettype none

module tb_flit_mux
  import flit_mux_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // packets per source
  localparam int num_pkts = 12;

  logic     clk;
  logic     rst = 1'b1;
  logic     stall;
  wire      in_mask_t in_valid;
  wire      flit_t in_flit [num_inputs];
  in_mask_t in_grant;
  logic     out_valid;
  flit_t    out_flit;

  // per-input packet streams and the idle gap before each packet
  flit_t flit_q [num_inputs][$];
  int    gap_q [num_inputs][$];

  logic [15:0] lfsr_state = 16'd23033;
  int total_flits = 0;
  int rx_count = 0;
  int stall_cnt = 0;
  int cycles = 0;
  int err_count = 0;

  // reference model state
  logic     busy = 1'b0;
  in_idx_t  ptr = '0;
  in_idx_t  lock = '0;
  int       left = 0;
  in_mask_t exp_grant = '0;
  logic     exp_valid = 1'b0;
  flit_t    exp_flit = '0;
  in_mask_t grant_q = '0;

  flit_mux_top DUT (
    .clk_i       (clk),
    .rst_i       (rst),
    .in_valid_i  (in_valid),
    .in_flit_i   (in_flit),
    .stall_i     (stall),
    .in_grant_o  (in_grant),
    .out_valid_o (out_valid),
    .out_flit_o  (out_flit)
  );

  // 16 bit fibonacci lfsr, taps 16 14 13 11, one step per bit
  function automatic logic [15:0] lfsr_take(input int nbits);
    logic [15:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < nbits; k++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r = {r[14:0], fb};
    end
    return r;
  endfunction

  // first requesting input at or after the pointer, cyclically
  function automatic in_idx_t next_winner(input in_idx_t from, input in_mask_t req);
    in_idx_t idx;
    idx = from;
    for (int k = 0; k < num_inputs; k++) begin
      if (req[idx]) begin
        return idx;
      end
      idx = in_idx_t'((int'(idx) + 1) % num_inputs);
    end
    return from;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      err_count++;
      $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, want);
      $display("=== FAIL ===");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // one source per input, holds each flit until its grant is seen
  for (genvar g = 0; g < num_inputs; g++) begin : g_src
    logic  valid;
    flit_t flit;
    assign in_valid[g] = valid;
    assign in_flit[g]  = flit;
    initial begin : run_source
      int n;
      valid = 1'b0;
      flit  = '0;
      wait (rst == 1'b0);
      while (gap_q[g].size() > 0) begin
        valid = 1'b0;
        repeat (gap_q[g].pop_front()) @(negedge clk);
        n = int'(flit_q[g][0].len);
        for (int k = 0; k <= n; k++) begin
          flit  = flit_q[g].pop_front();
          valid = 1'b1;
          do begin
            @(negedge clk);
          end while (!grant_q[g]);
        end
      end
      valid = 1'b0;
    end
  end

  // random back-pressure once the full round-robin phase is over
  initial begin : drive_stall
    stall = 1'b0;
    wait (rst == 1'b0);
    forever begin
      @(negedge clk);
      if (cycles > 60 && lfsr_take(2) == '0) begin
        stall = 1'b1;
        stall_cnt++;
      end else begin
        stall = 1'b0;
      end
    end
  end

  // expected grant and output from the inputs the sources drive
  always @(posedge clk) begin : ref_model
    in_mask_t heads;
    in_mask_t grant;
    in_idx_t  win;
    for (int i = 0; i < num_inputs; i++) begin
      heads[i] = in_valid[i] & in_flit[i].is_head;
    end
    grant = '0;
    win   = '0;
    if (rst) begin
      busy = 1'b0;
      ptr  = '0;
    end else if (stall) begin
      grant = '0;
    end else if (!busy && heads != '0) begin
      win = next_winner(ptr, heads);
      grant[win] = 1'b1;
      if (in_flit[win].len == '0) begin
        ptr = in_idx_t'((int'(win) + 1) % num_inputs);
      end else begin
        busy = 1'b1;
        lock = win;
        left = int'(in_flit[win].len);
      end
    end else if (busy && in_valid[lock]) begin
      win = lock;
      grant[win] = 1'b1;
      left--;
      if (left == 0) begin
        busy = 1'b0;
        ptr  = in_idx_t'((int'(lock) + 1) % num_inputs);
      end
    end
    exp_grant <= grant;
    exp_valid <= |grant;
    exp_flit  <= in_flit[win];
    grant_q   <= in_grant;
  end

  // compare half a cycle after the edge, all values settled
  initial begin : compare_outputs
    wait (rst == 1'b0);
    forever begin
      @(negedge clk);
      check_value("in_grant_o", 32'(grant_q), 32'(exp_grant));
      check_value("out_valid_o", 32'(out_valid), 32'(exp_valid));
      if (exp_valid) begin
        check_value("out_flit_o", 32'(out_flit), 32'(exp_flit));
        rx_count++;
      end
    end
  end

  initial begin : main
    int        gap;
    int        limit;
    flit_len_t len;
    flit_t     f;
    // quiet start, then four full packets per input, then sparse traffic
    for (int s = 0; s < num_inputs; s++) begin
      for (int p = 0; p < num_pkts; p++) begin
        gap = (p == 0) ? 3 : (p < 4) ? 0 : int'(lfsr_take(3));
        len = (p % 3 == 2) ? '0 : flit_len_t'(lfsr_take(len_w));
        gap_q[s].push_back(gap);
        for (int k = 0; k <= int'(len); k++) begin
          f.is_head = (k == 0);
          f.len     = (k == 0) ? len : '0;
          f.src     = in_idx_t'(s);
          f.payload = lfsr_take(data_w);
          flit_q[s].push_back(f);
        end
        total_flits += int'(len) + 1;
      end
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (rx_count < total_flits) begin
      @(posedge clk);
      cycles++;
      limit = 4 * total_flits + stall_cnt + 100;
      if (cycles > limit) begin
        $display("timeout, %0d of %0d flits left the mux in %0d cycles",
                 rx_count, total_flits, cycles);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
      end
    end
    // a few idle cycles catch any extra output flit
    repeat (10) @(posedge clk);
    if (err_count == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("=== FAIL ===");
      $fatal(1, "%0d mismatches", err_count);
    end
  end

endmodule

`default_nettype wire
